// File: compile.f
design/tart_ctrl_pkg.sv
design/axil_reg_bridge.sv
design/reset_pulse.sv
design/tart_control.sv
design/sample_fifo.sv
design/tart_ctrl_top.sv
sim/tb_tart_ctrl.sv

// File: design/axil_reg_bridge.sv
`default_nettype none

module axil_reg_bridge (
   input  logic                                  clk_i,
   input  logic                                  rst_i,
   // axi4-lite write address and data.
   input  logic                                  s_awvalid_i,
   output logic                                  s_awready_o,
   input  logic [tart_ctrl_pkg::axil_addr_w-1:0] s_awaddr_i,
   input  logic                                  s_wvalid_i,
   output logic                                  s_wready_o,
   input  logic [tart_ctrl_pkg::axil_data_w-1:0] s_wdata_i,
   // axi4-lite write response.
   output logic                                  s_bvalid_o,
   input  logic                                  s_bready_i,
   // axi4-lite read.
   input  logic                                  s_arvalid_i,
   output logic                                  s_arready_o,
   input  logic [tart_ctrl_pkg::axil_addr_w-1:0] s_araddr_i,
   output logic                                  s_rvalid_o,
   input  logic                                  s_rready_i,
   output logic [tart_ctrl_pkg::axil_data_w-1:0] s_rdata_o,
   // register strobe side.
   output logic                                  reg_wr_o,
   output tart_ctrl_pkg::reg_addr_t              reg_waddr_o,
   output logic [tart_ctrl_pkg::reg_w-1:0]       reg_wdata_o,
   output logic                                  reg_rd_o,
   output tart_ctrl_pkg::reg_addr_t              reg_raddr_o,
   input  logic [tart_ctrl_pkg::reg_w-1:0]       reg_rdata_i
);

   import tart_ctrl_pkg::*;

   logic             aw_rdy_q;  // awready and wready together.
   logic             b_vld_q;   // write response pending.
   logic             ar_rdy_q;  // read address accepted.
   logic             r_vld_q;   // read response pending.
   reg_addr_t        waddr_q;   // latched write index.
   logic [reg_w-1:0] wdata_q;   // latched write byte.
   reg_addr_t        raddr_q;   // latched read index.
   logic             wr_take;   // accept write next cycle.
   logic             rd_take;   // accept read next cycle.

   // both channels present, nothing outstanding.
   assign wr_take = s_awvalid_i && s_wvalid_i && !b_vld_q && !aw_rdy_q;
   assign rd_take = s_arvalid_i && !r_vld_q && !ar_rdy_q;

   //////////////////////////////
   // write path
   //////////////////////////////

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         aw_rdy_q <= 1'b0;
         b_vld_q  <= 1'b0;
      end else begin
         aw_rdy_q <= wr_take;           // one-cycle ready pulse.
         if (aw_rdy_q) begin
            b_vld_q <= 1'b1;            // response after handshake.
         end else if (s_bready_i) begin
            b_vld_q <= 1'b0;            // master took it.
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (wr_take) begin
         waddr_q <= s_awaddr_i[axil_addr_w-1 -: 2];  // word select.
         wdata_q <= s_wdata_i[reg_w-1:0];             // low byte only.
      end
   end

   //////////////////////////////
   // read path
   //////////////////////////////

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ar_rdy_q <= 1'b0;
         r_vld_q  <= 1'b0;
      end else begin
         ar_rdy_q <= rd_take;
         if (ar_rdy_q) begin
            r_vld_q <= 1'b1;            // data registered by now.
         end else if (s_rready_i) begin
            r_vld_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_take) begin
         raddr_q <= s_araddr_i[axil_addr_w-1 -: 2];
      end
   end

   assign s_awready_o = aw_rdy_q;
   assign s_wready_o  = aw_rdy_q;
   assign s_bvalid_o  = b_vld_q;
   assign s_arready_o = ar_rdy_q;
   assign s_rvalid_o  = r_vld_q;
   // register block holds its data word until the next read strobe.
   assign s_rdata_o   = {{(axil_data_w - reg_w){1'b0}}, reg_rdata_i};

   assign reg_wr_o    = aw_rdy_q;       // strobe in handshake cycle.
   assign reg_waddr_o = waddr_q;
   assign reg_wdata_o = wdata_q;
   assign reg_rd_o    = ar_rdy_q;
   assign reg_raddr_o = raddr_q;

   //////////////////////////////
   // protocol checks
   //////////////////////////////

   a_bvalid_hold : assert property (@(posedge clk_i) disable iff (rst_i)
      s_bvalid_o && !s_bready_i |=> s_bvalid_o)
      else $error("bvalid dropped before bready");

   a_wr_single : assert property (@(posedge clk_i) disable iff (rst_i)
      reg_wr_o |=> !reg_wr_o)
      else $error("reg_wr_o held for two cycles");

endmodule : axil_reg_bridge

`default_nettype wire

// File: design/reset_pulse.sv
`default_nettype none

module reset_pulse #(
   parameter int unsigned RTIME = tart_ctrl_pkg::rtime_default
) (
   input  logic clk_i,
   input  logic rst_i,
   input  logic req_i,      // single-cycle host request.
   input  logic reset_ni,   // external request, active low.
   output logic reset_o,
   output logic busy_o
);

   localparam int unsigned CNT_W = $clog2(RTIME + 1);

   logic [CNT_W-1:0] cnt_q;   // cycles of pulse left.
   logic             load;    // any request this cycle.

   assign load = req_i || !reset_ni;

   // reload on every request, so a late request restarts the pulse.
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         cnt_q <= '0;
      end else if (load) begin
         cnt_q <= CNT_W'(RTIME);
      end else if (cnt_q != '0) begin
         cnt_q <= cnt_q - CNT_W'(1);   // count down to idle.
      end
   end

   assign reset_o = (cnt_q != '0);     // high for RTIME cycles.
   assign busy_o  = (cnt_q != '0);     // status bit for reads.

   //////////////////////////////
   // pulse length check
   //////////////////////////////

   // RTIME quiet cycles after the last request end the pulse.
   a_pulse_len : assert property (@(posedge clk_i) disable iff (rst_i)
      load ##1 (!load) [*RTIME] |=> !reset_o)
      else $error("reset_o longer than RTIME cycles");

endmodule : reset_pulse

`default_nettype wire

// File: design/sample_fifo.sv
`default_nettype none

module sample_fifo #(
   parameter int unsigned FIFO_DEPTH = tart_ctrl_pkg::fifo_depth_default
) (
   input  logic                            clk_i,
   input  logic                            rst_i,
   input  logic                            clear_i,     // capture reset pulse.
   // sample stream in, no back-pressure.
   input  logic                            wr_valid_i,
   input  logic [tart_ctrl_pkg::reg_w-1:0] wr_data_i,
   // read port.
   input  logic                            rd_ready_i,
   output logic                            rd_valid_o,
   output logic [tart_ctrl_pkg::reg_w-1:0] rd_data_o,
   // status.
   output logic [tart_ctrl_pkg::reg_w-1:0] fill_level_o,
   output logic                            overflow_o,
   output logic                            underrun_o
);

   import tart_ctrl_pkg::*;

   localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

   logic [reg_w-1:0] mem [FIFO_DEPTH];  // sample storage.
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;           // entries held.
   logic             overflow_q;
   logic             underrun_q;
   logic             full;
   logic             empty;
   logic             wr_en;
   logic             rd_en;

   // wrap at FIFO_DEPTH, depth need not be a power of two.
   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
         return '0;
      end
      return ptr + PTR_W'(1);
   endfunction

   assign full  = (count_q == CNT_W'(FIFO_DEPTH));
   assign empty = (count_q == '0);
   assign wr_en = wr_valid_i && !full;    // drop while full.
   assign rd_en = rd_ready_i && !empty;

   //////////////////////////////
   // storage
   //////////////////////////////

   always_ff @(posedge clk_i) begin
      if (wr_en) begin
         mem[wr_ptr_q] <= wr_data_i;
      end
   end

   //////////////////////////////
   // pointers, count and flags
   //////////////////////////////

   always_ff @(posedge clk_i) begin
      if (rst_i || clear_i) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         count_q    <= '0;
         overflow_q <= 1'b0;
         underrun_q <= 1'b0;
      end else begin
         if (wr_en) begin
            wr_ptr_q <= ptr_next(wr_ptr_q);
         end
         if (rd_en) begin
            rd_ptr_q <= ptr_next(rd_ptr_q);
         end
         case ({wr_en, rd_en})
            2'b10:   count_q <= count_q + CNT_W'(1);
            2'b01:   count_q <= count_q - CNT_W'(1);
            default: count_q <= count_q;  // idle or both.
         endcase
         if (wr_valid_i && full) begin
            overflow_q <= 1'b1;           // sticky.
         end
         if (rd_ready_i && empty) begin
            underrun_q <= 1'b1;           // sticky.
         end
      end
   end

   assign rd_valid_o   = !empty;
   assign rd_data_o    = mem[rd_ptr_q];   // head of queue.
   assign fill_level_o = reg_w'(count_q);
   assign overflow_o   = overflow_q;
   assign underrun_o   = underrun_q;

   //////////////////////////////
   // checks
   //////////////////////////////

   a_count_max : assert property (@(posedge clk_i) disable iff (rst_i)
      count_q <= CNT_W'(FIFO_DEPTH))
      else $error("fifo count above depth: %0d", count_q);

endmodule : sample_fifo

`default_nettype wire

// File: design/tart_control.sv
`default_nettype none

module tart_control #(
   parameter int unsigned RTIME = tart_ctrl_pkg::rtime_default
) (
   input  logic                            clk_i,
   input  logic                            rst_i,
   // register strobes from the bus bridge.
   input  logic                            reg_wr_i,
   input  tart_ctrl_pkg::reg_addr_t        reg_waddr_i,
   input  logic [tart_ctrl_pkg::reg_w-1:0] reg_wdata_i,
   input  logic                            reg_rd_i,
   input  tart_ctrl_pkg::reg_addr_t        reg_raddr_i,
   output logic [tart_ctrl_pkg::reg_w-1:0] reg_rdata_o,
   // capture fifo status.
   input  logic [tart_ctrl_pkg::reg_w-1:0] fill_level_i,
   input  logic                            overflow_i,
   input  logic                            underrun_i,
   // reset request and pulse.
   input  logic                            reset_ni,
   output logic                            reset_o
);

   import tart_ctrl_pkg::*;

   logic [reg_w-1:0] misc_q;     // scratch register.
   logic [reg_w-1:0] flags;      // extra flags word.
   logic [reg_w-1:0] rdata_q;    // registered read word.
   logic             rst_req;    // host write to reset reg.
   logic             rst_busy;   // pulse still running.

   assign flags   = {flags_pattern, overflow_i, underrun_i};
   assign rst_req = reg_wr_i && (reg_waddr_i == addr_reset);  // data ignored.

   //////////////////////////////
   // writable registers
   //////////////////////////////

   // only rst_i clears misc, the capture reset pulse leaves it alone.
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         misc_q <= misc_rst_val;
      end else if (reg_wr_i && (reg_waddr_i == addr_misc)) begin
         misc_q <= reg_wdata_i;
      end
   end

   //////////////////////////////
   // read decode
   //////////////////////////////

   always_ff @(posedge clk_i) begin
      if (reg_rd_i) begin
         case (reg_raddr_i)
            addr_status: rdata_q <= fill_level_i;   // sampled at strobe.
            addr_flags:  rdata_q <= flags;
            addr_misc:   rdata_q <= misc_q;
            default:     rdata_q <= {{(reg_w - 1){1'b0}}, rst_busy};  // reset reg.
         endcase
      end
   end

   assign reg_rdata_o = rdata_q;

   //////////////////////////////
   // reset generator
   //////////////////////////////

   reset_pulse #(
      .RTIME (RTIME)
   ) reset_pulse_inst (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .req_i    (rst_req),
      .reset_ni (reset_ni),
      .reset_o  (reset_o),
      .busy_o   (rst_busy)
   );

endmodule : tart_control

`default_nettype wire

// File: design/tart_ctrl_pkg.sv
`default_nettype none

package tart_ctrl_pkg;

   //////////////////////////////
   // widths
   //////////////////////////////

   localparam int unsigned reg_w       = 8;   // register data width.
   localparam int unsigned axil_data_w = 32;  // bus word, regs in bits 7..0.
   localparam int unsigned axil_addr_w = 4;   // byte address, 4 words.

   typedef logic [1:0] reg_addr_t;            // word index, bits 3..2.

   //////////////////////////////
   // register map
   //////////////////////////////

   localparam reg_addr_t addr_status = 2'd0;  // fifo fill level.
   localparam reg_addr_t addr_flags  = 2'd1;  // pattern plus sticky flags.
   localparam reg_addr_t addr_misc   = 2'd2;  // scratch, read/write.
   localparam reg_addr_t addr_reset  = 2'd3;  // reset pulse control.

   //////////////////////////////
   // reset values and constants
   //////////////////////////////

   localparam logic [reg_w-1:0] misc_rst_val = 8'h3e;

   // upper six bits of the flags word, reads 0xcc with flags clear.
   localparam logic [5:0] flags_pattern = 6'b110011;

   localparam int unsigned rtime_default      = 4;  // pulse length, cycles.
   localparam int unsigned fifo_depth_default = 8;  // capture fifo entries.

endpackage : tart_ctrl_pkg

`default_nettype wire

// File: design/tart_ctrl_top.sv
`default_nettype none

module tart_ctrl_top #(
   parameter int unsigned RTIME      = tart_ctrl_pkg::rtime_default,
   parameter int unsigned FIFO_DEPTH = tart_ctrl_pkg::fifo_depth_default
) (
   input  logic                                  clk_i,
   input  logic                                  rst_i,
   // axi4-lite slave.
   input  logic                                  s_awvalid_i,
   output logic                                  s_awready_o,
   input  logic [tart_ctrl_pkg::axil_addr_w-1:0] s_awaddr_i,
   input  logic                                  s_wvalid_i,
   output logic                                  s_wready_o,
   input  logic [tart_ctrl_pkg::axil_data_w-1:0] s_wdata_i,
   output logic                                  s_bvalid_o,
   input  logic                                  s_bready_i,
   input  logic                                  s_arvalid_i,
   output logic                                  s_arready_o,
   input  logic [tart_ctrl_pkg::axil_addr_w-1:0] s_araddr_i,
   output logic                                  s_rvalid_o,
   input  logic                                  s_rready_i,
   output logic [tart_ctrl_pkg::axil_data_w-1:0] s_rdata_o,
   // sample stream and read port.
   input  logic                                  samp_valid_i,
   input  logic [tart_ctrl_pkg::reg_w-1:0]       samp_data_i,
   input  logic                                  out_ready_i,
   output logic                                  out_valid_o,
   output logic [tart_ctrl_pkg::reg_w-1:0]       out_data_o,
   // capture reset.
   input  logic                                  reset_ni,
   output logic                                  reset_o
);

   import tart_ctrl_pkg::*;

   logic             reg_wr;        // write strobe.
   reg_addr_t        reg_waddr;
   logic [reg_w-1:0] reg_wdata;
   logic             reg_rd;        // read strobe.
   reg_addr_t        reg_raddr;
   logic [reg_w-1:0] reg_rdata;
   logic [reg_w-1:0] fill_level;
   logic             overflow;
   logic             underrun;

   axil_reg_bridge axil_reg_bridge_inst (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .s_awvalid_i (s_awvalid_i),
      .s_awready_o (s_awready_o),
      .s_awaddr_i  (s_awaddr_i),
      .s_wvalid_i  (s_wvalid_i),
      .s_wready_o  (s_wready_o),
      .s_wdata_i   (s_wdata_i),
      .s_bvalid_o  (s_bvalid_o),
      .s_bready_i  (s_bready_i),
      .s_arvalid_i (s_arvalid_i),
      .s_arready_o (s_arready_o),
      .s_araddr_i  (s_araddr_i),
      .s_rvalid_o  (s_rvalid_o),
      .s_rready_i  (s_rready_i),
      .s_rdata_o   (s_rdata_o),
      .reg_wr_o    (reg_wr),
      .reg_waddr_o (reg_waddr),
      .reg_wdata_o (reg_wdata),
      .reg_rd_o    (reg_rd),
      .reg_raddr_o (reg_raddr),
      .reg_rdata_i (reg_rdata)
   );

   tart_control #(
      .RTIME (RTIME)
   ) tart_control_inst (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .reg_wr_i     (reg_wr),
      .reg_waddr_i  (reg_waddr),
      .reg_wdata_i  (reg_wdata),
      .reg_rd_i     (reg_rd),
      .reg_raddr_i  (reg_raddr),
      .reg_rdata_o  (reg_rdata),
      .fill_level_i (fill_level),
      .overflow_i   (overflow),
      .underrun_i   (underrun),
      .reset_ni     (reset_ni),
      .reset_o      (reset_o)
   );

   // pulse clears the fifo and also leaves on the pin.
   sample_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) sample_fifo_inst (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .clear_i      (reset_o),
      .wr_valid_i   (samp_valid_i),
      .wr_data_i    (samp_data_i),
      .rd_ready_i   (out_ready_i),
      .rd_valid_o   (out_valid_o),
      .rd_data_o    (out_data_o),
      .fill_level_o (fill_level),
      .overflow_o   (overflow),
      .underrun_o   (underrun)
   );

endmodule : tart_ctrl_top

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert \
   --top-module tb_tart_ctrl \
   -f compile.f \
   -o tb_tart_ctrl
./obj_dir/tb_tart_ctrl

// File: sim/tb_tart_ctrl.sv
`default_nettype none

module tb_tart_ctrl;

   import tart_ctrl_pkg::*;

   localparam int         rtime          = 4;
   localparam int         fifo_depth     = 8;
   localparam int         timeout_cycles = 2000;        // traffic is about 400 cycles.
   localparam logic [7:0] misc_init      = 8'h3e;       // misc after rst_i.
   localparam logic [5:0] flag_bits      = 6'b110011;   // fixed top of flags word.

   logic        clk_i;
   logic        rst_i;
   logic        s_awvalid_i;
   logic        s_awready_o;
   logic [3:0]  s_awaddr_i;
   logic        s_wvalid_i;
   logic        s_wready_o;
   logic [31:0] s_wdata_i;
   logic        s_bvalid_o;
   logic        s_bready_i;
   logic        s_arvalid_i;
   logic        s_arready_o;
   logic [3:0]  s_araddr_i;
   logic        s_rvalid_o;
   logic        s_rready_i;
   logic [31:0] s_rdata_o;
   logic        samp_valid_i;
   logic [7:0]  samp_data_i;
   logic        out_ready_i;
   logic        out_valid_o;
   logic [7:0]  out_data_o;
   logic        reset_ni;
   logic        reset_o;

   logic [7:0]  ref_q [$];      // expected fifo contents.
   logic [7:0]  m_level;        // expected fill level.
   logic [7:0]  m_head;         // expected head sample.
   logic [7:0]  m_misc;
   logic        m_ovf;
   logic        m_unf;
   int          m_cnt;          // pulse cycles left.
   logic [7:0]  exp_rdata;      // word due at read response.
   int          cycle_cnt = 0;
   integer      seed = 32'h5759;

   tart_ctrl_top #(
      .RTIME      (rtime),
      .FIFO_DEPTH (fifo_depth)
   ) tart_ctrl_top_inst (.*);

   initial begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;
   end

   //////////////////////////////
   // reference model
   //////////////////////////////

   always @(posedge clk_i) begin : ref_model
      int lvl;
      lvl = ref_q.size();
      if (rst_i) begin
         ref_q.delete();
         m_ovf  <= 1'b0;
         m_unf  <= 1'b0;
         m_misc <= misc_init;
         m_cnt  <= 0;
      end else begin
         if (s_arready_o) begin                       // strobe cycle value.
            case (s_araddr_i[3:2])
               addr_status: exp_rdata <= m_level;
               addr_flags:  exp_rdata <= {flag_bits, m_ovf, m_unf};
               addr_misc:   exp_rdata <= m_misc;
               default:     exp_rdata <= {7'b0, m_cnt != 0};
            endcase
         end
         if (s_awvalid_i && s_awready_o && s_awaddr_i[3:2] == addr_misc) begin
            m_misc <= s_wdata_i[7:0];
         end
         if ((s_awvalid_i && s_awready_o && s_awaddr_i[3:2] == addr_reset) || !reset_ni) begin
            m_cnt <= rtime;                           // restart on any request.
         end else if (m_cnt != 0) begin
            m_cnt <= m_cnt - 1;
         end
         if (m_cnt != 0) begin
            ref_q.delete();                           // pulse clears the capture.
            m_ovf <= 1'b0;
            m_unf <= 1'b0;
         end else begin
            if (samp_valid_i && lvl == fifo_depth) begin
               m_ovf <= 1'b1;
            end
            if (out_ready_i && lvl == 0) begin
               m_unf <= 1'b1;
            end
            if (out_ready_i && lvl != 0) begin
               void'(ref_q.pop_front());
            end
            if (samp_valid_i && lvl < fifo_depth) begin
               ref_q.push_back(samp_data_i);          // full drops the sample.
            end
         end
      end
      m_level <= 8'(ref_q.size());
      m_head  <= (ref_q.size() != 0) ? ref_q[0] : 8'h00;
   end

   //////////////////////////////
   // checks
   //////////////////////////////

   a_rdata : assert property (@(posedge clk_i) disable iff (rst_i)
      s_rvalid_o |-> s_rdata_o == {24'h0, exp_rdata})
      else stop_on_error($sformatf("error: s_rdata_o got %h expected %h",
         $sampled(s_rdata_o), {24'h0, $sampled(exp_rdata)}));

   a_out_valid : assert property (@(posedge clk_i) disable iff (rst_i)
      out_valid_o == (m_level != 8'h00))
      else stop_on_error($sformatf("error: out_valid_o got %h expected %h",
         $sampled(out_valid_o), $sampled(m_level) != 8'h00));

   a_out_data : assert property (@(posedge clk_i) disable iff (rst_i)
      out_valid_o |-> out_data_o == m_head)
      else stop_on_error($sformatf("error: out_data_o got %h expected %h",
         $sampled(out_data_o), $sampled(m_head)));

   a_reset_o : assert property (@(posedge clk_i) disable iff (rst_i)
      reset_o == (m_cnt != 0))
      else stop_on_error($sformatf("error: reset_o got %h expected %h",
         $sampled(reset_o), $sampled(m_cnt) != 0));

   // address and data channels are taken in the same cycle.
   a_wready : assert property (@(posedge clk_i) disable iff (rst_i)
      s_wready_o == s_awready_o)
      else stop_on_error($sformatf("error: s_wready_o got %h expected %h",
         $sampled(s_wready_o), $sampled(s_awready_o)));

   a_bresp : assert property (@(posedge clk_i) disable iff (rst_i)
      s_awready_o |=> s_bvalid_o)
      else stop_on_error("write response did not follow the write handshake");

   a_rresp : assert property (@(posedge clk_i) disable iff (rst_i)
      s_arready_o |=> s_rvalid_o)
      else stop_on_error("read response did not follow the read handshake");

   a_bhold : assert property (@(posedge clk_i) disable iff (rst_i)
      s_bvalid_o && !s_bready_i |=> s_bvalid_o && !s_awready_o)
      else stop_on_error("held write response dropped or a second write got through");

   // all handshakes and the pulse idle once reset lets go.
   a_reset_state : assert property (@(posedge clk_i)
      $fell(rst_i) |-> !(s_awready_o || s_wready_o || s_arready_o || s_bvalid_o
                         || s_rvalid_o || reset_o || out_valid_o))
      else stop_on_error("outputs not idle right after reset");

   //////////////////////////////
   // bus and stream tasks
   //////////////////////////////

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("RESULT: FAIL");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic send_write(input reg_addr_t addr, input logic [7:0] data);
      @(posedge clk_i);
      s_awvalid_i <= 1'b1;
      s_wvalid_i  <= 1'b1;
      s_awaddr_i  <= {addr, 2'b00};
      s_wdata_i   <= {24'h0, data};
      do begin
         @(posedge clk_i);
      end while (!s_awready_o);
      s_awvalid_i <= 1'b0;
      s_wvalid_i  <= 1'b0;
   endtask

   task automatic take_write_resp(input int delay);
      do begin
         @(posedge clk_i);
      end while (!s_bvalid_o);
      repeat (delay) @(posedge clk_i);                // bready late on purpose.
      s_bready_i <= 1'b1;
      @(posedge clk_i);
      s_bready_i <= 1'b0;
   endtask

   task automatic write_reg(input reg_addr_t addr, input logic [7:0] data);
      int delay;
      delay = $random(seed) & 3;
      send_write(addr, data);
      take_write_resp(delay);
   endtask

   task automatic read_reg(input reg_addr_t addr);
      int delay;
      delay = $random(seed) & 3;
      @(posedge clk_i);
      s_arvalid_i <= 1'b1;
      s_araddr_i  <= {addr, 2'b00};
      do begin
         @(posedge clk_i);
      end while (!s_arready_o);
      s_arvalid_i <= 1'b0;
      do begin
         @(posedge clk_i);
      end while (!s_rvalid_o);
      repeat (delay) @(posedge clk_i);
      s_rready_i <= 1'b1;
      @(posedge clk_i);
      s_rready_i <= 1'b0;
   endtask

   task automatic push_samples(input int n);
      int i;
      for (i = 0; i < n; i++) begin
         @(posedge clk_i);
         samp_valid_i <= 1'b1;
         samp_data_i  <= 8'($random(seed));
      end
      @(posedge clk_i);
      samp_valid_i <= 1'b0;
   endtask

   task automatic drain_fifo(input int n);
      @(posedge clk_i);
      out_ready_i <= 1'b1;                            // ready for n cycles.
      repeat (n) @(posedge clk_i);
      out_ready_i <= 1'b0;
   endtask

   task automatic pulse_reset_n();
      @(posedge clk_i);
      reset_ni <= 1'b0;
      @(posedge clk_i);
      reset_ni <= 1'b1;
   endtask

   task automatic wait_pulse_end();
      do begin
         @(posedge clk_i);
      end while (reset_o);
   endtask

   //////////////////////////////
   // stimulus
   //////////////////////////////

   always @(posedge clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   initial begin
      wait (cycle_cnt >= timeout_cycles);
      stop_on_error("timeout: test did not finish within the cycle limit");
   end

   initial begin
      rst_i        = 1'b1;
      s_awvalid_i  = 1'b0;
      s_awaddr_i   = 4'h0;
      s_wvalid_i   = 1'b0;
      s_wdata_i    = 32'h0;
      s_bready_i   = 1'b0;
      s_arvalid_i  = 1'b0;
      s_araddr_i   = 4'h0;
      s_rready_i   = 1'b0;
      samp_valid_i = 1'b0;
      samp_data_i  = 8'h00;
      out_ready_i  = 1'b0;
      reset_ni     = 1'b1;
      repeat (8) @(posedge clk_i);
      rst_i <= 1'b0;
      read_reg(addr_status);                          // values out of reset.
      read_reg(addr_flags);
      read_reg(addr_misc);
      read_reg(addr_reset);
      write_reg(addr_misc, 8'ha5);
      write_reg(addr_status, 8'h55);                  // read-only, ignored.
      write_reg(addr_flags, 8'h77);
      read_reg(addr_misc);
      read_reg(addr_status);
      read_reg(addr_flags);
      push_samples(3);
      read_reg(addr_status);
      push_samples(7);                                // two past full.
      read_reg(addr_status);
      read_reg(addr_flags);
      drain_fifo(fifo_depth);
      read_reg(addr_status);
      drain_fifo(1);                                  // ready on empty.
      read_reg(addr_flags);
      // host pulse, read lands mid-pulse.
      push_samples(2);
      fork
         write_reg(addr_reset, 8'h01);
         begin
            repeat (2) @(posedge clk_i);
            read_reg(addr_reset);
         end
      join
      wait_pulse_end();
      read_reg(addr_status);
      read_reg(addr_flags);
      read_reg(addr_misc);
      // external request.
      push_samples(3);
      fork
         pulse_reset_n();
         read_reg(addr_reset);
      join
      wait_pulse_end();
      read_reg(addr_status);
      read_reg(addr_flags);
      // second write waits behind a held response.
      send_write(addr_misc, 8'h11);
      fork
         send_write(addr_misc, 8'h22);
         take_write_resp(6);
      join
      take_write_resp(1);
      read_reg(addr_misc);
      repeat (4) @(posedge clk_i);
      $display("RESULT: PASS");
      $finish;
   end

endmodule : tb_tart_ctrl

`default_nettype wire
